// File: compile.f
+incdir+design
design/mips_pkg.sv
design/mem_port_if.sv
design/bus_arbiter.sv
design/fetch_unit.sv
design/load_store_unit.sv
design/register_file.sv
design/exec_control.sv
design/mips_cpu.sv
sim/avalon_ram.sv
sim/mips_cpu_properties.sv
sim/mips_cpu_tb.sv

// File: design/bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         waitrequest,
    input  logic [31:0]  readdata,
    output logic [31:0]  address,
    output logic [31:0]  writedata,
    output logic         read,
    output logic         write,
    mem_port_if.arbiter  fetch_port,
    mem_port_if.arbiter  data_port
);
    logic        busy;
    logic        resp;
    logic        grant_data;
    logic [31:0] rdata_q;

    // Grant and bus strobes. The data port wins a tie.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            resp       <= 1'b0;
            grant_data <= 1'b0;
            read       <= 1'b0;
            write      <= 1'b0;
        end else begin
            resp <= 1'b0;
            if (!busy && !resp) begin
                if (data_port.req) begin
                    busy       <= 1'b1;
                    grant_data <= 1'b1;
                    read       <= !data_port.write;
                    write      <= data_port.write;
                end else if (fetch_port.req) begin
                    busy       <= 1'b1;
                    grant_data <= 1'b0;
                    read       <= 1'b1;
                    write      <= 1'b0;
                end
            end else if (busy && !waitrequest) begin
                busy  <= 1'b0;
                resp  <= 1'b1;
                read  <= 1'b0;
                write <= 1'b0;
            end
        end
    end

    // Address and data are captured at grant and held until the access ends.
    always_ff @(posedge clk) begin
        if (!busy && !resp) begin
            if (data_port.req) begin
                address   <= data_port.addr;
                writedata <= data_port.wdata;
            end else if (fetch_port.req) begin
                address   <= fetch_port.addr;
                writedata <= fetch_port.wdata;
            end
        end
        if (busy && read && !waitrequest) begin
            rdata_q <= readdata;
        end
    end

    assign fetch_port.rdata = rdata_q;
    assign data_port.rdata  = rdata_q;
    assign fetch_port.done  = resp && !grant_data;
    assign data_port.done   = resp && grant_data;

endmodule

`default_nettype wire

// File: design/exec_control.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module exec_control (
    input  logic             clk,
    input  logic             rst_n,
    input  mips_pkg::instr_t instr,
    input  logic             instr_valid,
    input  logic             mem_done,
    input  logic [31:0]      load_data,
    output logic             active,
    output logic             fetch_start,
    output logic             pc_next,
    output logic             pc_jump,
    output logic             mem_start,
    output logic             is_store,
    output logic [31:0]      jump_target,
    output logic [31:0]      mem_addr,
    output logic [31:0]      store_data,
    output logic [4:0]       rs_addr,
    output logic [4:0]       rt_addr,
    input  logic [31:0]      rs_data,
    input  logic [31:0]      rt_data,
    output logic [4:0]       wr_addr,
    output logic             wr_en,
    output logic [31:0]      wr_data
);
    import mips_pkg::*;

    ctrl_state_t state;
    logic        is_rtype;
    logic        is_jr;
    logic        is_mem;
    logic        writes_reg;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic [31:0] alu_result;

    // Decode and ALU. The opcode picks which union view is read.
    always_comb begin
        is_rtype   = (instr.r.opcode == OP_SPECIAL);
        imm_sext   = {{16{instr.i.imm[15]}}, instr.i.imm};
        imm_zext   = {16'd0, instr.i.imm};
        is_jr      = 1'b0;
        is_mem     = 1'b0;
        is_store   = 1'b0;
        writes_reg = 1'b0;
        alu_result = 32'd0;
        if (is_rtype) begin
            rs_addr = instr.r.rs;
            rt_addr = instr.r.rt;
            wr_addr = instr.r.rd;
            writes_reg = 1'b1;
            case (instr.r.funct)
                FN_ADDU: alu_result = rs_data + rt_data;
                FN_SUBU: alu_result = rs_data - rt_data;
                FN_AND:  alu_result = rs_data & rt_data;
                FN_OR:   alu_result = rs_data | rt_data;
                FN_XOR:  alu_result = rs_data ^ rt_data;
                FN_JR: begin
                    is_jr      = 1'b1;
                    writes_reg = 1'b0;
                end
                default: writes_reg = 1'b0;
            endcase
        end else begin
            rs_addr = instr.i.rs;
            rt_addr = instr.i.rt;
            wr_addr = instr.i.rt;
            writes_reg = 1'b1;
            case (instr.i.opcode)
                OP_ADDIU: alu_result = rs_data + imm_sext;
                OP_ANDI:  alu_result = rs_data & imm_zext;
                OP_ORI:   alu_result = rs_data | imm_zext;
                OP_XORI:  alu_result = rs_data ^ imm_zext;
                OP_LW: begin
                    is_mem     = 1'b1;
                    writes_reg = 1'b0;
                end
                OP_SW: begin
                    is_mem     = 1'b1;
                    is_store   = 1'b1;
                    writes_reg = 1'b0;
                end
                default: writes_reg = 1'b0;
            endcase
        end
    end

    assign mem_addr    = rs_data + imm_sext;
    assign store_data  = rt_data;
    assign jump_target = rs_data;

    // Loads write back when the data unit answers.
    assign wr_en   = (state == S_EXEC && writes_reg) || (state == S_MEM && mem_done && !is_store);
    assign wr_data = (state == S_MEM) ? load_data : alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_FETCH;
            active      <= 1'b0;
            fetch_start <= 1'b0;
            pc_next     <= 1'b0;
            pc_jump     <= 1'b0;
            mem_start   <= 1'b0;
        end else begin
            fetch_start <= 1'b0;
            pc_next     <= 1'b0;
            pc_jump     <= 1'b0;
            mem_start   <= 1'b0;
            case (state)
                S_FETCH: begin
                    // First cycle out of reset launches the first fetch.
                    if (!active) begin
                        active      <= 1'b1;
                        fetch_start <= 1'b1;
                    end else if (instr_valid) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (is_jr && jump_target == `MIPS_HALT_ADDR) begin
                        active <= 1'b0;
                        state  <= S_HALT;
                    end else if (is_jr) begin
                        pc_jump     <= 1'b1;
                        fetch_start <= 1'b1;
                        state       <= S_FETCH;
                    end else if (is_mem) begin
                        mem_start <= 1'b1;
                        state     <= S_MEM;
                    end else begin
                        pc_next     <= 1'b1;
                        fetch_start <= 1'b1;
                        state       <= S_FETCH;
                    end
                end
                S_MEM: begin
                    if (mem_done) begin
                        pc_next     <= 1'b1;
                        fetch_start <= 1'b1;
                        state       <= S_FETCH;
                    end
                end
                default: state <= S_HALT;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module fetch_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetch_start,
    input  logic             pc_next,
    input  logic             pc_jump,
    input  logic [31:0]      jump_target,
    output mips_pkg::instr_t instr,
    output logic             instr_valid,
    mem_port_if.requester    port
);
    logic [31:0] pc;
    logic        req;

    // Program counter.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `MIPS_RESET_VECTOR;
        end else if (pc_jump) begin
            pc <= jump_target;
        end else if (pc_next) begin
            pc <= pc + 32'd4;
        end
    end

    // Request is held from fetch_start until the arbiter answers.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req         <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= port.done;
            if (fetch_start) begin
                req <= 1'b1;
            end else if (port.done) begin
                req <= 1'b0;
            end
        end
    end

    // Instruction word stays put until the next fetch completes.
    always_ff @(posedge clk) begin
        if (port.done) begin
            instr <= port.rdata;
        end
    end

    assign port.req   = req;
    assign port.write = 1'b0;
    assign port.addr  = pc;
    assign port.wdata = 32'd0;

endmodule

`default_nettype wire

// File: design/load_store_unit.sv
`timescale 1ns/10ps
`default_nettype none

module load_store_unit (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          mem_start,
    input  logic          is_store,
    input  logic [31:0]   addr,
    input  logic [31:0]   store_data,
    output logic [31:0]   load_data,
    output logic          mem_done,
    mem_port_if.requester port
);
    logic        req;
    logic        write_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req      <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= port.done;
            if (mem_start) begin
                req <= 1'b1;
            end else if (port.done) begin
                req <= 1'b0;
            end
        end
    end

    // Access details captured once at the start.
    always_ff @(posedge clk) begin
        if (mem_start) begin
            write_q <= is_store;
            addr_q  <= addr;
            wdata_q <= store_data;
        end
        if (port.done) begin
            load_data <= port.rdata;
        end
    end

    assign port.req   = req;
    assign port.write = write_q;
    assign port.addr  = addr_q;
    assign port.wdata = wdata_q;

endmodule

`default_nettype wire

// File: design/mem_port_if.sv
`timescale 1ns/10ps
`default_nettype none

// One requester's path to the shared memory port.
interface mem_port_if;
    logic        req;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        done;

    modport requester (
        output req, write, addr, wdata,
        input  rdata, done
    );

    modport arbiter (
        input  req, write, addr, wdata,
        output rdata, done
    );
endinterface

`default_nettype wire

// File: design/mips_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module mips_cpu (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        waitrequest,
    input  logic [31:0] readdata,
    output logic        active,
    output logic        read,
    output logic        write,
    output logic [31:0] address,
    output logic [31:0] writedata,
    output logic [31:0] register_v0
);
    import mips_pkg::*;

    instr_t      instr;
    logic        instr_valid;
    logic        fetch_start;
    logic        pc_next;
    logic        pc_jump;
    logic        mem_start;
    logic        mem_done;
    logic        is_store;
    logic        wr_en;
    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [4:0]  wr_addr;
    logic [31:0] jump_target;
    logic [31:0] mem_addr;
    logic [31:0] store_data;
    logic [31:0] load_data;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] wr_data;

    // Instruction and data requests share the one Avalon master.
    mem_port_if fetch_bus ();
    mem_port_if data_bus ();

    bus_arbiter u_arbiter (
        .clk(clk), .rst_n(rst_n), .waitrequest(waitrequest), .readdata(readdata),
        .address(address), .writedata(writedata), .read(read), .write(write),
        .fetch_port(fetch_bus), .data_port(data_bus)
    );

    fetch_unit u_fetch (
        .clk(clk), .rst_n(rst_n), .fetch_start(fetch_start), .pc_next(pc_next),
        .pc_jump(pc_jump), .jump_target(jump_target), .instr(instr),
        .instr_valid(instr_valid), .port(fetch_bus)
    );

    load_store_unit u_lsu (
        .clk(clk), .rst_n(rst_n), .mem_start(mem_start), .is_store(is_store),
        .addr(mem_addr), .store_data(store_data), .load_data(load_data),
        .mem_done(mem_done), .port(data_bus)
    );

    register_file u_regs (
        .clk(clk), .rst_n(rst_n), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .wr_addr(wr_addr), .wr_en(wr_en), .wr_data(wr_data),
        .rs_data(rs_data), .rt_data(rt_data), .v0(register_v0)
    );

    exec_control u_ctrl (
        .clk(clk), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid),
        .mem_done(mem_done), .load_data(load_data), .active(active),
        .fetch_start(fetch_start), .pc_next(pc_next), .pc_jump(pc_jump),
        .mem_start(mem_start), .is_store(is_store), .jump_target(jump_target),
        .mem_addr(mem_addr), .store_data(store_data), .rs_addr(rs_addr),
        .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
        .wr_addr(wr_addr), .wr_en(wr_en), .wr_data(wr_data)
    );

endmodule

`default_nettype wire

// File: design/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Address of the first instruction fetched after reset.
`define MIPS_RESET_VECTOR 32'h0000_0004

// A jr to this address ends the run.
`define MIPS_HALT_ADDR 32'h0000_0000

// Number of general purpose registers.
`define MIPS_NUM_REGS 32

`endif

// File: design/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // Primary opcodes of the supported subset.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // Function codes used under OP_SPECIAL.
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // One instruction word, seen as R-type or I-type.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module register_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic [4:0]  wr_addr,
    input  logic        wr_en,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] v0
);
    logic [31:0] regs [`MIPS_NUM_REGS];

    // Register zero is never written, so it keeps its reset value.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0      = regs[2];

endmodule

`default_nettype wire

// File: sim/avalon_ram.sv
`timescale 1ns/10ps
`default_nettype none

// Word-addressed memory behind an Avalon slave port.
module avalon_ram (
    input  logic        clk,
    input  logic        stall,
    input  logic [31:0] address,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    output logic [31:0] readdata
);
    logic [31:0] mem [256];

    // Stall cycles come from the random stall input.
    assign waitrequest = stall;

    // Read data follows the address, so it is valid in the cycle that ends a read.
    assign readdata = mem[address[9:2]];

    always @(posedge clk) begin
        if (write && !waitrequest) begin
            mem[address[9:2]] <= writedata;
        end
    end

    // Preload of one word, used while the core is held in reset.
    task automatic load_word(input logic [7:0] index, input logic [31:0] data);
        mem[index] <= data;
    endtask

    function automatic logic [31:0] read_word(input logic [7:0] index);
        return mem[index];
    endfunction

endmodule

`default_nettype wire

// File: sim/mips_cpu_properties.sv
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        waitrequest,
    input logic        read,
    input logic        write,
    input logic        active,
    input logic [31:0] address,
    input logic [31:0] writedata
);
    int failures = 0;

    // A stalled read keeps its strobe and address.
    read_held: assert property (@(posedge clk) disable iff (!rst_n)
        (read && waitrequest) |=> (read && $stable(address)))
    else begin
        failures++;
        $error("read or address changed while waitrequest was high");
    end

    // A stalled write keeps its strobe, address and data.
    write_held: assert property (@(posedge clk) disable iff (!rst_n)
        (write && waitrequest) |=> (write && $stable(address) && $stable(writedata)))
    else begin
        failures++;
        $error("write, address or writedata changed while waitrequest was high");
    end

    one_strobe: assert property (@(posedge clk) disable iff (!rst_n) !(read && write))
    else begin
        failures++;
        $error("read and write were high together");
    end

    // Once reset has been seen for a full cycle the master is quiet.
    quiet_in_reset: assert property (@(posedge clk)
        (!rst_n ##1 !rst_n) |-> (!read && !write && !active))
    else begin
        failures++;
        $error("bus strobe or active high during reset");
    end

endmodule

`default_nettype wire

// File: sim/mips_cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module mips_cpu_tb;
    import mips_pkg::*;

    localparam int NUM_PROGS    = 20;
    localparam int PROG_WORDS   = 25;
    localparam int RESET_CYCLES = 3;
    localparam int SETTLE       = 6;
    localparam int CYCLE_LIMIT  = NUM_PROGS * (PROG_WORDS + 1) * 16
                                  + NUM_PROGS * (RESET_CYCLES + SETTLE + 2);
    // Data region is word 64 to 71, reached from base register $7.
    localparam int DATA_FIRST   = 64;
    localparam int DATA_WORDS   = 8;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        active;
    logic        read;
    logic        write;
    logic [31:0] address;
    logic [31:0] writedata;
    logic [31:0] register_v0;

    integer      seed = 5;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count;
    int          emit_idx;
    logic [31:0] image [256];
    logic [31:0] model_mem [256];
    logic [31:0] model_reg [`MIPS_NUM_REGS];

    mips_cpu uut (
        .clk(clk), .rst_n(rst_n), .waitrequest(waitrequest), .readdata(readdata),
        .active(active), .read(read), .write(write), .address(address),
        .writedata(writedata), .register_v0(register_v0)
    );

    avalon_ram ram (
        .clk(clk), .stall(stall), .address(address), .write(write),
        .writedata(writedata), .waitrequest(waitrequest), .readdata(readdata)
    );

    bind mips_cpu mips_cpu_properties props (
        .clk(clk), .rst_n(rst_n), .waitrequest(waitrequest), .read(read),
        .write(write), .active(active), .address(address), .writedata(writedata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // About one cycle in four is stalled.
    always @(posedge clk) begin
        stall <= (($random(seed) & 3) == 0);
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles: the processor never halted", cycle_count);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic logic [31:0] encode_r(funct_t fn, logic [4:0] rs, logic [4:0] rt,
                                             logic [4:0] rd);
        instr_t w;
        w.r.opcode = OP_SPECIAL;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = 5'd0;
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic logic [31:0] encode_i(opcode_t op, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] imm);
        instr_t w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    task automatic emit(input logic [31:0] w);
        image[emit_idx] = w;
        emit_idx++;
    endtask

    task automatic random_instr(output logic [31:0] w);
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [15:0] imm;
        logic [15:0] offset;
        kind   = {$random(seed)} % 12;
        rs     = 5'({$random(seed)} % 8);
        rt     = 5'({$random(seed)} % 8);
        dest   = 5'({$random(seed)} % 7);
        imm    = 16'($random(seed));
        // $7 holds 0x200, so a negative offset lands in the data region.
        offset = 16'hff00 + 16'(4 * ({$random(seed)} % DATA_WORDS));
        case (kind)
            0: w = encode_r(FN_ADDU, rs, rt, dest);
            1: w = encode_r(FN_SUBU, rs, rt, dest);
            2: w = encode_r(FN_AND, rs, rt, dest);
            3: w = encode_r(FN_OR, rs, rt, dest);
            4: w = encode_r(FN_XOR, rs, rt, dest);
            5: w = encode_i(OP_ADDIU, rs, dest, imm);
            6: w = encode_i(OP_ANDI, rs, dest, imm);
            7: w = encode_i(OP_ORI, rs, dest, imm);
            8: w = encode_i(OP_XORI, rs, dest, imm);
            9, 10: w = encode_i(OP_LW, 5'd7, dest, offset);
            default: w = encode_i(OP_SW, 5'd7, rt, offset);
        endcase
    endtask

    task automatic build_program();
        logic [31:0] w;
        logic [31:0] byte_addr;
        for (int i = 0; i < 256; i++) begin
            byte_addr = 32'(i) << 2;
            image[i]  = {~byte_addr[15:0], byte_addr[15:0]};
        end
        for (int k = 0; k < DATA_WORDS; k++) begin
            image[DATA_FIRST + k] = $random(seed);
        end
        emit_idx = `MIPS_RESET_VECTOR >> 2;
        for (int r = 1; r < 7; r++) begin
            emit(encode_i(OP_ADDIU, 5'd0, 5'(r), 16'($random(seed))));
        end
        emit(encode_i(OP_ADDIU, 5'd0, 5'd7, 16'h0200));
        for (int n = 0; n < 15; n++) begin
            random_instr(w);
            emit(w);
        end
        // The write to $0 must be lost, and $2 then reads $0.
        emit(encode_i(OP_ADDIU, 5'd3, 5'd0, 16'h1234));
        emit(encode_r(FN_ADDU, 5'd2, 5'd0, 5'd2));
        emit(encode_r(FN_JR, 5'd0, 5'd0, 5'd0));
        for (int i = 0; i < 256; i++) begin
            ram.load_word(8'(i), image[i]);
            model_mem[i] = image[i];
        end
    endtask

    // ISA reference model, one instruction per step.
    task automatic run_model();
        instr_t      iw;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] ea;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        we;
        logic        halted;
        int          steps;
        for (int r = 0; r < `MIPS_NUM_REGS; r++) begin
            model_reg[r] = 32'd0;
        end
        pc     = `MIPS_RESET_VECTOR;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < 2 * PROG_WORDS) begin
            iw     = model_mem[pc[9:2]];
            a      = model_reg[iw.r.rs];
            b      = model_reg[iw.r.rt];
            sx     = {{16{iw.i.imm[15]}}, iw.i.imm};
            zx     = {16'd0, iw.i.imm};
            ea     = a + sx;
            we     = 1'b1;
            dest   = iw.i.rt;
            result = 32'd0;
            pc     = pc + 32'd4;
            if (iw.r.opcode == OP_SPECIAL) begin
                dest = iw.r.rd;
                case (iw.r.funct)
                    FN_ADDU: result = a + b;
                    FN_SUBU: result = a - b;
                    FN_AND:  result = a & b;
                    FN_OR:   result = a | b;
                    FN_XOR:  result = a ^ b;
                    FN_JR: begin
                        we     = 1'b0;
                        halted = (a == `MIPS_HALT_ADDR);
                        pc     = a;
                    end
                    default: we = 1'b0;
                endcase
            end else begin
                case (iw.i.opcode)
                    OP_ADDIU: result = a + sx;
                    OP_ANDI:  result = a & zx;
                    OP_ORI:   result = a | zx;
                    OP_XORI:  result = a ^ zx;
                    OP_LW:    result = model_mem[ea[9:2]];
                    OP_SW: begin
                        model_mem[ea[9:2]] = b;
                        we = 1'b0;
                    end
                    default: we = 1'b0;
                endcase
            end
            if (we && dest != 5'd0) begin
                model_reg[dest] = result;
            end
            steps++;
        end
        if (!halted) begin
            errors++;
            $display("Reference model never reached the halting jr");
        end
    endtask

    task automatic run_program(input int p);
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        build_program();
        run_model();
        compare($sformatf("prog %0d active in reset", p), 32'(active), 32'd0);
        compare($sformatf("prog %0d read in reset", p), 32'(read), 32'd0);
        compare($sformatf("prog %0d write in reset", p), 32'(write), 32'd0);
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // Active rises at the first clock edge that sees reset released.
        @(posedge clk);
        @(negedge clk);
        compare($sformatf("prog %0d active after reset", p), 32'(active), 32'd1);
        while (active) begin
            @(negedge clk);
        end
        // Halted. The core must stay idle from here on.
        repeat (SETTLE) begin
            @(negedge clk);
            compare($sformatf("prog %0d active after halt", p), 32'(active), 32'd0);
            compare($sformatf("prog %0d bus after halt", p), 32'(read | write), 32'd0);
        end
        compare($sformatf("prog %0d register_v0", p), register_v0, model_reg[2]);
        for (int k = 0; k < DATA_WORDS; k++) begin
            compare($sformatf("prog %0d data word %0d", p, k),
                    ram.read_word(8'(DATA_FIRST + k)), model_mem[DATA_FIRST + k]);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        stall = 1'b0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, uut.props.failures);
        if (errors == 0 && uut.props.failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
